//--- rtl/ddr_test_pkg.sv
// shared widths, address limits, LFSR seeds, bus structs and FSM enums
package ddr_test_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int num_lanes = 8;
  localparam int data_w    = 64;
  localparam int row_w     = 13;
  localparam int col_w     = 9;
  localparam int bank_w    = 2;

  // --------------------
  // sweep limits
  // --------------------
  localparam logic [row_w-1:0]  max_row     = 13'd3;
  localparam logic [col_w-1:0]  max_col     = 9'd16;
  localparam logic [bank_w-1:0] max_bank    = 2'd3;
  localparam logic              max_chipsel = 1'b0;
  // one local beat covers four column addresses
  localparam logic [col_w-1:0]  col_step    = 9'd4;

  // lane i starts from 10*i + 1
  localparam logic [num_lanes-1:0][7:0] lane_seeds = {
    8'd71, 8'd61, 8'd51, 8'd41, 8'd31, 8'd21, 8'd11, 8'd1
  };

  // passes run in this order when enabled
  localparam logic seq_addr_on = 1'b1;
  localparam logic dm_pin_on   = 1'b1;
  localparam logic addr_pin_on = 1'b1;

  typedef struct packed {
    logic              cs;
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
    logic [col_w-1:0]  col;
  } mem_addr_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              rdata_valid;
  } rd_resp_t;

  typedef logic [num_lanes-1:0] byte_en_t;

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_dm_fill,
    st_dm_drain,
    st_dm_rearm,
    st_write,
    st_write_end,
    st_read,
    st_read_drain,
    st_done
  } test_state_e;

  typedef enum logic [1:0] {
    mode_none,
    mode_seq_addr,
    mode_dm_pin,
    mode_addr_pin
  } test_mode_e;

endpackage

//--- rtl/lfsr8.sv
// 8-bit Fibonacci LFSR lane with seed, load, enable and pause
`timescale 1ns/1ps

module lfsr8 (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [7:0] seed,
  input  logic       enable,
  input  logic       load,
  input  logic [7:0] ldata,
  input  logic       pause,
  output logic [7:0] data
);

  logic feedback;

  // taps 7, 5, 4, 3
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      data <= seed;
    end
    else if (load)
    begin
      // rewind to a stored starting point
      data <= ldata;
    end
    else if (enable && !pause)
    begin
      data <= {data[6:0], feedback};
    end
  end

endmodule

//--- rtl/data_gen.sv
// per-lane LFSR bank, starting-state capture and write data zero mux
`timescale 1ns/1ps

module data_gen
  import ddr_test_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              step,
  input  logic              capture_seed,
  input  logic              lfsr_load,
  input  logic              lfsr_enable,
  input  logic              reset_data,
  output logic [data_w-1:0] wdata,
  output logic [data_w-1:0] lane_data
);

  logic [data_w-1:0] ldata;

  // one generator per byte lane
  for (genvar i = 0; i < num_lanes; i++)
  begin : g_lane
    lfsr8 u_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .seed    (lane_seeds[i]),
      .enable  (lfsr_enable),
      .load    (lfsr_load),
      .ldata   (ldata[8*i +: 8]),
      .pause   (!step),
      .data    (lane_data[8*i +: 8])
    );
  end

  // state at the first write of a pass, replayed for the read-back
  always_ff @(posedge clk)
  begin
    if (capture_seed)
      ldata <= lane_data;
  end

  // zero fill during the first sweep of the DM pass
  assign wdata = reset_data ? '0 : lane_data;

endmodule

//--- rtl/test_sequencer.sv
// pass FSM, request levels, outstanding-read counter and pass mode flags
`timescale 1ns/1ps

module test_sequencer
  import ddr_test_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       local_ready,
  input  logic       rdata_valid,
  input  logic       reached_max,
  output logic       write_req,
  output logic       read_req,
  output test_mode_e mode,
  output logic       reset_address,
  output logic       reset_be,
  output logic       reset_data,
  output logic       capture_seed,
  output logic       lfsr_load,
  output logic       lfsr_enable,
  output logic       test_complete
);

  test_state_e state;
  logic        seq_addr_pend;
  logic        dm_pin_pend;
  logic        addr_pin_pend;
  logic [7:0]  rd_outstanding;
  logic        write_accept;
  logic        read_accept;

  assign write_accept = write_req & local_ready;
  assign read_accept  = read_req & local_ready;

  // --------------------
  // reads in flight
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_outstanding <= '0;
    else if (read_accept && !rdata_valid)
      rd_outstanding <= rd_outstanding + 8'd1;
    else if (!read_accept && rdata_valid && rd_outstanding != '0)
      rd_outstanding <= rd_outstanding - 8'd1;
  end

  // --------------------
  // pass state machine
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= st_idle;
      mode          <= mode_none;
      seq_addr_pend <= 1'b0;
      dm_pin_pend   <= 1'b0;
      addr_pin_pend <= 1'b0;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      reset_address <= 1'b0;
      reset_be      <= 1'b0;
      reset_data    <= 1'b0;
      capture_seed  <= 1'b0;
      lfsr_load     <= 1'b0;
      lfsr_enable   <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          seq_addr_pend <= seq_addr_on;
          dm_pin_pend   <= dm_pin_on;
          addr_pin_pend <= addr_pin_on;
          test_complete <= 1'b0;
          state         <= st_start;
        end

        st_start:
        begin
          reset_address <= 1'b0;
          reset_be      <= 1'b0;
          lfsr_enable   <= 1'b1;
          capture_seed  <= seq_addr_pend | dm_pin_pend | addr_pin_pend;
          // lowest pending pass goes first
          if (seq_addr_pend)
          begin
            mode      <= mode_seq_addr;
            write_req <= 1'b1;
            state     <= st_write;
          end
          else if (dm_pin_pend)
          begin
            mode       <= mode_dm_pin;
            reset_data <= 1'b1;
            write_req  <= 1'b1;
            state      <= st_dm_fill;
          end
          else if (addr_pin_pend)
          begin
            mode      <= mode_addr_pin;
            write_req <= 1'b1;
            state     <= st_write;
          end
          else
          begin
            state <= st_done;
          end
        end

        // zero writes over the whole region
        st_dm_fill:
        begin
          capture_seed <= 1'b0;
          if (write_accept && reached_max)
          begin
            write_req <= 1'b0;
            state     <= st_dm_drain;
          end
        end

        st_dm_drain:
        begin
          reset_be      <= 1'b1;
          reset_address <= 1'b1;
          lfsr_load     <= 1'b1;
          state         <= st_dm_rearm;
        end

        // masked rewrite starts from the same address and data
        st_dm_rearm:
        begin
          reset_be      <= 1'b0;
          reset_address <= 1'b0;
          lfsr_load     <= 1'b0;
          reset_data    <= 1'b0;
          write_req     <= 1'b1;
          state         <= st_write;
        end

        st_write:
        begin
          capture_seed <= 1'b0;
          if (write_accept && reached_max)
          begin
            reset_address <= 1'b1;
            write_req     <= 1'b0;
            state         <= st_write_end;
          end
        end

        st_write_end:
        begin
          reset_address <= 1'b0;
          lfsr_load     <= 1'b1;
          reset_be      <= 1'b1;
          read_req      <= 1'b1;
          state         <= st_read;
        end

        st_read:
        begin
          lfsr_load <= 1'b0;
          reset_be  <= 1'b0;
          if (read_accept && reached_max)
          begin
            read_req <= 1'b0;
            state    <= st_read_drain;
          end
        end

        // hold until every read has been answered
        st_read_drain:
        begin
          if (rd_outstanding == '0)
          begin
            reset_address <= 1'b1;
            mode          <= mode_none;
            case (mode)
              mode_seq_addr: seq_addr_pend <= 1'b0;
              mode_dm_pin:   dm_pin_pend   <= 1'b0;
              mode_addr_pin: addr_pin_pend <= 1'b0;
              default:       ;
            endcase
            state <= st_start;
          end
        end

        st_done:
        begin
          reset_address <= 1'b0;
          lfsr_enable   <= 1'b0;
          test_complete <= 1'b1;
          state         <= st_idle;
        end

        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- rtl/addr_gen.sv
// sequential and walking-one address counter with end-of-region flag
`timescale 1ns/1ps

module addr_gen
  import ddr_test_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       reset_address,
  input  logic       advance,
  input  test_mode_e mode,
  output mem_addr_t  addr,
  output logic       reached_max
);

  logic last_seq;

  assign last_seq = (addr.col == max_col) && (addr.row == max_row) &&
                    (addr.bank == max_bank) && (addr.cs == max_chipsel);

  // walking pattern ends when the row is all ones
  assign reached_max = (addr.row == {row_w{1'b1}}) || last_seq;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr <= '0;
    end
    else if (reset_address)
    begin
      addr <= '0;
    end
    else if (advance)
    begin
      if (mode == mode_addr_pin)
      begin
        // --------------------
        // one-hot walk
        // --------------------
        if (addr.row == '0)
        begin
          addr.row <= 13'd1;
          addr.col <= 9'd4;
        end
        else if (addr.row == {1'b1, {(row_w-1){1'b0}}})
        begin
          // switch to a walking zero
          addr.row <= {{(row_w-1){1'b1}}, 1'b0};
          addr.col <= 9'b111111000;
        end
        else if (addr.row == {1'b0, {(row_w-1){1'b1}}})
        begin
          addr.row <= {row_w{1'b1}};
          addr.col <= 9'b111111100;
        end
        else
        begin
          addr.row           <= {addr.row[row_w-2:0], addr.row[row_w-1]};
          addr.col[col_w-1:2] <= {addr.col[col_w-2:2], addr.col[col_w-1]};
        end
        // bank and chip select toggle on every step
        addr.bank <= (addr.bank == max_bank) ? '0 : addr.bank + 1'b1;
        addr.cs   <= (addr.cs == max_chipsel) ? 1'b0 : addr.cs + 1'b1;
      end
      else if (addr.col >= max_col)
      begin
        // column wraps, carry into row, bank, cs
        addr.col <= '0;
        if (addr.row != max_row)
          addr.row <= addr.row + 1'b1;
        else
        begin
          addr.row <= '0;
          if (addr.bank != max_bank)
            addr.bank <= addr.bank + 1'b1;
          else
          begin
            addr.bank <= '0;
            addr.cs   <= (addr.cs == max_chipsel) ? 1'b0 : addr.cs + 1'b1;
          end
        end
      end
      else
      begin
        addr.col <= addr.col + col_step;
      end
    end
  end

endmodule

//--- rtl/byte_enable_gen.sv
// rotating one-hot byte enable for the masked DM pass
`timescale 1ns/1ps

module byte_enable_gen
  import ddr_test_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     reset_be,
  input  logic     rotate,
  input  logic     dm_mode,
  input  logic     reset_data,
  output byte_en_t be
);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (reset_be && dm_mode)
      // masked sweeps start on lane 0
      be <= {{(num_lanes-1){1'b0}}, 1'b1};
    else if (rotate && dm_mode)
      be <= {be[num_lanes-2:0], be[num_lanes-1]};
    else if (reset_data || !dm_mode)
      // full writes outside the masked sweep
      be <= '1;
  end

endmodule

//--- rtl/read_checker.sv
// masked per-lane read compare, result pipeline and sticky pass flag
`timescale 1ns/1ps

module read_checker
  import ddr_test_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  rd_resp_t             resp,
  input  logic [data_w-1:0]    lane_data,
  input  byte_en_t             be,
  output logic [num_lanes-1:0] pnf_per_byte,
  output logic                 pnf_persist
);

  logic [num_lanes-1:0] compare;
  logic [num_lanes-1:0] compare_reg;
  logic [num_lanes-1:0] compare_valid;
  logic                 last_valid;
  logic                 pnf_sticky;

  // disabled lanes are expected to read back zero
  always_comb
  begin
    for (int i = 0; i < num_lanes; i++)
      compare[i] = (lane_data[8*i +: 8] & {8{be[i]}}) == resp.rdata[8*i +: 8];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg   <= '1;
      compare_valid <= '1;
      pnf_per_byte  <= '1;
      last_valid    <= 1'b0;
      pnf_sticky    <= 1'b1;
      pnf_persist   <= 1'b1;
    end
    else
    begin
      compare_reg <= compare;
      last_valid  <= resp.rdata_valid;
      // only a real beat updates the result
      if (last_valid)
        compare_valid <= compare_reg;
      if (!(&compare_valid))
        pnf_sticky <= 1'b0;
      pnf_per_byte <= compare_valid;
      pnf_persist  <= pnf_sticky;
    end
  end

endmodule

//--- rtl/ddr_example_driver.sv
// top level of the traffic driver, block wiring and the status word
`timescale 1ns/1ps

module ddr_example_driver
  import ddr_test_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 local_ready,
  input  logic [data_w-1:0]    local_rdata,
  input  logic                 local_rdata_valid,
  output mem_addr_t            local_addr,
  output byte_en_t             local_be,
  output logic [data_w-1:0]    local_wdata,
  output logic                 local_write_req,
  output logic                 local_read_req,
  output logic [num_lanes-1:0] pnf_per_byte,
  output logic                 pnf_persist,
  output logic                 test_complete,
  output logic [7:0]           test_status
);

  rd_resp_t          resp;
  test_mode_e        mode;
  logic              reset_address;
  logic              reset_be;
  logic              reset_data;
  logic              capture_seed;
  logic              lfsr_load;
  logic              lfsr_enable;
  logic              reached_max;
  logic              advance;
  logic              step;
  logic [data_w-1:0] lane_data;

  assign resp.rdata       = local_rdata;
  assign resp.rdata_valid = local_rdata_valid;

  // --------------------
  // handshake events
  // --------------------
  assign advance = (local_write_req | local_read_req) & local_ready;
  // zero-fill writes leave the data sequence untouched
  assign step    = (local_write_req & local_ready & ~reset_data) | resp.rdata_valid;

  test_sequencer u_sequencer (
    .clk           (clk),
    .reset_n       (reset_n),
    .local_ready   (local_ready),
    .rdata_valid   (resp.rdata_valid),
    .reached_max   (reached_max),
    .write_req     (local_write_req),
    .read_req      (local_read_req),
    .mode          (mode),
    .reset_address (reset_address),
    .reset_be      (reset_be),
    .reset_data    (reset_data),
    .capture_seed  (capture_seed),
    .lfsr_load     (lfsr_load),
    .lfsr_enable   (lfsr_enable),
    .test_complete (test_complete)
  );

  addr_gen u_addr_gen (
    .clk           (clk),
    .reset_n       (reset_n),
    .reset_address (reset_address),
    .advance       (advance),
    .mode          (mode),
    .addr          (local_addr),
    .reached_max   (reached_max)
  );

  data_gen u_data_gen (
    .clk          (clk),
    .reset_n      (reset_n),
    .step         (step),
    .capture_seed (capture_seed),
    .lfsr_load    (lfsr_load),
    .lfsr_enable  (lfsr_enable),
    .reset_data   (reset_data),
    .wdata        (local_wdata),
    .lane_data    (lane_data)
  );

  byte_enable_gen u_be_gen (
    .clk        (clk),
    .reset_n    (reset_n),
    .reset_be   (reset_be),
    .rotate     (step),
    .dm_mode    (mode == mode_dm_pin),
    .reset_data (reset_data),
    .be         (local_be)
  );

  read_checker u_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .resp         (resp),
    .lane_data    (lane_data),
    .be           (local_be),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

  // one-hot pass indication, bit 7 marks the end of a run
  assign test_status = {test_complete, 3'b000, mode == mode_addr_pin,
                        mode == mode_dm_pin, 1'b0, mode == mode_seq_addr};

endmodule

//--- tests/tb_ddr_driver.sv
// testbench for the DDR traffic driver with memory model, reference functions and checks
`timescale 1ns/1ps

module tb_ddr_driver
  import ddr_test_pkg::*;
();

  localparam int seq_len           = 80;
  localparam int walk_len          = 28;
  localparam int expected_accesses = 3 * seq_len + walk_len;
  // two runs, each allowed 20 cycles per access
  localparam int cycle_limit       = 2 * 20 * expected_accesses;
  localparam int fault_read        = 5;
  localparam int fault_lane        = 3;
  localparam int fault_bit         = 2;

  logic                 clk;
  logic                 reset_n;
  logic                 local_ready;
  logic [data_w-1:0]    local_rdata;
  logic                 local_rdata_valid;
  mem_addr_t            local_addr;
  byte_en_t             local_be;
  logic [data_w-1:0]    local_wdata;
  logic                 local_write_req;
  logic                 local_read_req;
  logic [num_lanes-1:0] pnf_per_byte;
  logic                 pnf_persist;
  logic                 test_complete;
  logic [7:0]           test_status;

  int                errors = 0;
  int                checks = 0;
  int                cycle = 0;
  bit                fault_on;
  bit                run_done;
  int                seq_wr, seq_rd, dm_wr, dm_rd, walk_wr, walk_rd;
  int                last_due;
  mem_addr_t         exp_wr_addr;
  mem_addr_t         exp_rd_addr;
  logic [3:0]        last_modes;
  byte_en_t          seen_low;
  logic [3:0]        mode_order[$];
  logic [data_w-1:0] resp_data[$];
  int                resp_due[$];
  logic [data_w-1:0] mem[int];

  ddr_example_driver dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------
  function automatic logic [7:0] lfsr_step(input logic [7:0] d);
    return {d[6:0], d[7] ^ d[5] ^ d[4] ^ d[3]};
  endfunction

  // data after start+k lane steps from the seeds, be one-hot rotating when masked
  function automatic logic [data_w+num_lanes-1:0] expected_write(input int start, input int k,
                                                                 input bit masked);
    logic [data_w-1:0] data;
    logic [7:0]        lane;
    byte_en_t          be;
    for (int i = 0; i < num_lanes; i++)
    begin
      lane = 8'(10 * i + 1);
      for (int s = 0; s < start + k; s++)
        lane = lfsr_step(lane);
      data[8*i +: 8] = lane;
    end
    be = masked ? byte_en_t'(1 << (k % num_lanes)) : '1;
    return {data, be};
  endfunction

  function automatic mem_addr_t next_seq_addr(input mem_addr_t a);
    mem_addr_t n;
    n = a;
    if (a.col < max_col)
      n.col = a.col + col_step;
    else
    begin
      n.col = '0;
      if (a.row < max_row)
        n.row = a.row + 13'd1;
      else
      begin
        n.row = '0;
        if (a.bank < max_bank)
          n.bank = a.bank + 2'd1;
        else
        begin
          n.bank = '0;
          n.cs   = 1'b0;
        end
      end
    end
    return n;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0d ns %s: got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // --------------------
  // bus observation
  // --------------------
  task automatic record_write();
    logic [data_w+num_lanes-1:0] ew;
    logic [data_w-1:0]           merged;
    if (test_status[0])
    begin
      ew = expected_write(0, seq_wr, 1'b0);
      check(64'(local_addr), 64'(exp_wr_addr), "sequential write address");
      check(local_wdata, ew[data_w+num_lanes-1:num_lanes], "sequential write data");
      check(64'(local_be), 64'(ew[num_lanes-1:0]), "sequential write be");
      exp_wr_addr = next_seq_addr(exp_wr_addr);
      seq_wr++;
    end
    else if (test_status[2])
    begin
      if (dm_wr < seq_len)
      begin
        check(local_wdata, '0, "zero-fill write data");
        check(64'(local_be), 64'(8'hff), "zero-fill write be");
      end
      else
      begin
        // masked sweep starts where the sequential read-back left the lanes
        ew = expected_write(seq_len, dm_wr - seq_len, 1'b1);
        check(local_wdata, ew[data_w+num_lanes-1:num_lanes], "masked write data");
        check(64'(local_be), 64'(ew[num_lanes-1:0]), "masked write be");
      end
      dm_wr++;
    end
    else if (test_status[3])
      walk_wr++;
    merged = mem.exists(int'(local_addr)) ? mem[int'(local_addr)] : '0;
    for (int i = 0; i < num_lanes; i++)
      if (local_be[i])
        merged[8*i +: 8] = local_wdata[8*i +: 8];
    mem[int'(local_addr)] = merged;
  endtask

  task automatic record_read();
    logic [data_w-1:0] data;
    int                due;
    data = mem.exists(int'(local_addr)) ? mem[int'(local_addr)] : '0;
    if (test_status[0])
    begin
      check(64'(local_addr), 64'(exp_rd_addr), "sequential read address");
      exp_rd_addr = next_seq_addr(exp_rd_addr);
      seq_rd++;
    end
    else if (test_status[2])
    begin
      if (fault_on && dm_rd == fault_read)
        data[8*fault_lane + fault_bit] = ~data[8*fault_lane + fault_bit];
      dm_rd++;
    end
    else if (test_status[3])
      walk_rd++;
    // responses stay in order, one beat per cycle
    due = cycle + 1 + int'($urandom % 4);
    if (due <= last_due)
      due = last_due + 1;
    last_due = due;
    resp_data.push_back(data);
    resp_due.push_back(due);
  endtask

  task automatic observe_bus();
    logic [2:0] modes;
    modes = {test_status[3], test_status[2], test_status[0]};
    check(64'({test_status[6:4], test_status[1]}), 64'(0), "unused status bits");
    if ($countones(modes) > 1)
      check(64'(modes), 64'(0), "more than one mode bit set");
    if (test_status[3:0] != 4'h0 && test_status[3:0] != last_modes)
      mode_order.push_back(test_status[3:0]);
    last_modes = test_status[3:0];
    if (local_write_req && local_ready)
      record_write();
    if (local_read_req && local_ready)
      record_read();
    seen_low = seen_low | ~pnf_per_byte;
    if (test_complete)
    begin
      check(64'(test_status[7]), 64'(1), "status bit 7 with test_complete");
      run_done = 1'b1;
    end
  endtask

  // inputs change on the falling edge, outputs are read 1 ns later
  always @(negedge clk)
  begin
    if (resp_due.size() > 0 && resp_due[0] <= cycle)
    begin
      local_rdata_valid = 1'b1;
      local_rdata       = resp_data.pop_front();
      void'(resp_due.pop_front());
    end
    else
    begin
      local_rdata_valid = 1'b0;
      local_rdata       = '0;
    end
    local_ready = ($urandom % 4) != 0;
    #1;
    if (reset_n)
      observe_bus();
  end

  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("timeout: the driver did not complete within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // run control
  // --------------------
  task automatic start_run();
    @(negedge clk);
    reset_n = 1'b0;
    resp_data.delete();
    resp_due.delete();
    mode_order.delete();
    mem.delete();
    {seq_wr, seq_rd, dm_wr, dm_rd, walk_wr, walk_rd} = '0;
    last_due      = 0;
    exp_wr_addr   = '0;
    exp_rd_addr   = '0;
    last_modes    = 4'h0;
    seen_low      = '0;
    run_done      = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic end_of_run();
    // the completion pulse is gone one cycle later
    @(negedge clk);
    check(64'(test_complete), 64'(0), "test_complete longer than one cycle");
    check(64'(seq_wr), 64'(seq_len), "sequential write count");
    check(64'(seq_rd), 64'(seq_len), "sequential read count");
    check(64'(dm_wr), 64'(2 * seq_len), "DM write count");
    check(64'(dm_rd), 64'(seq_len), "DM read count");
    check(64'(walk_wr), 64'(walk_len), "address-pin write count");
    check(64'(walk_rd), 64'(walk_len), "address-pin read count");
    check(64'(mode_order.size()), 64'(3), "number of passes");
    if (mode_order.size() == 3)
      check(64'({mode_order[0], mode_order[1], mode_order[2]}), 64'(12'h148), "pass order");
    if (fault_on)
    begin
      check(64'(seen_low), 64'(1 << fault_lane), "lanes flagged by the fault");
      check(64'(pnf_persist), 64'(0), "pnf_persist after fault");
    end
    else
    begin
      check(64'(seen_low), 64'(0), "lanes flagged without fault");
      check(64'(pnf_persist), 64'(1), "pnf_persist without fault");
    end
  endtask

  initial
  begin
    void'($urandom(53));
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata       = '0;
    local_rdata_valid = 1'b0;
    fault_on          = 1'b0;
    start_run();
    wait (run_done);
    end_of_run();
    // second run with one corrupted read beat in the DM pass
    fault_on = 1'b1;
    start_run();
    wait (run_done);
    end_of_run();
    $display("run finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- build.f
rtl/ddr_test_pkg.sv
rtl/lfsr8.sv
rtl/data_gen.sv
rtl/test_sequencer.sv
rtl/addr_gen.sv
rtl/byte_enable_gen.sv
rtl/read_checker.sv
rtl/ddr_example_driver.sv
tests/tb_ddr_driver.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f build.f --top-module tb_ddr_driver -o tb_ddr_driver \
  && ./obj_dir/tb_ddr_driver | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
